/* include/rv_core_macros.svh */
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// Data path width.
`define RV_XLEN 32

// Architectural integer registers, x0 included.
`define RV_NUM_REGS 32

// Unified memory depth in 32-bit words.
`define RV_MEM_WORDS 512

// First fetch address after reset.
`define RV_RESET_PC 32'h0000_0000

`endif

/* src/rv_core_pkg.sv */
`default_nettype none

`include "rv_core_macros.svh"

package rv_core_pkg;

	// RV32I major opcodes.
	typedef enum logic [6:0] {
		LOAD     = 7'b0000011,
		STORE    = 7'b0100011,
		BRANCH   = 7'b1100011,
		JALR     = 7'b1100111,
		MISC_MEM = 7'b0001111,
		JAL      = 7'b1101111,
		OP_IMM   = 7'b0010011,
		OP       = 7'b0110011,
		SYSTEM   = 7'b1110011,
		AUIPC    = 7'b0010111,
		LUI      = 7'b0110111
	} opcode_e;

	// Encoded as {funct7[5], funct3}.
	typedef enum logic [3:0] {
		ADD  = 4'b0000,
		SUB  = 4'b1000,
		SLL  = 4'b0001,
		SLT  = 4'b0010,
		SLTU = 4'b0011,
		XOR  = 4'b0100,
		SRL  = 4'b0101,
		SRA  = 4'b1101,
		OR   = 4'b0110,
		AND  = 4'b0111
	} alu_op_e;

	typedef enum logic [1:0] {
		BYTE = 2'b00,
		HALF = 2'b01,
		WORD = 2'b10
	} mem_size_e;

	typedef struct packed {
		opcode_e                          opcode;
		logic [$clog2(`RV_NUM_REGS)-1:0] rd;
		logic [$clog2(`RV_NUM_REGS)-1:0] rs1;
		logic [$clog2(`RV_NUM_REGS)-1:0] rs2;
		logic [2:0]                       funct3;
		alu_op_e                          alu_op;
		logic [`RV_XLEN-1:0]              imm; // Already sign-extended.
		mem_size_e                        size;
		logic                             is_unsigned;
		logic                             illegal;
	} decoded_t;

	typedef struct packed {
		logic [`RV_XLEN-3:0] addr; // Word index, not a byte address.
		logic [3:0]          be;
		logic [`RV_XLEN-1:0] data;
	} dmem_req_t;

	typedef struct packed {
		logic                             valid;
		logic [`RV_XLEN-1:0]              pc;
		logic [`RV_XLEN-1:0]              insn;
		logic                             rd_we;
		logic [$clog2(`RV_NUM_REGS)-1:0] rd_idx;
		logic [`RV_XLEN-1:0]              rd_data;
		dmem_req_t                        store; // be is zero when nothing is stored.
	} retire_t;

endpackage

`default_nettype wire

/* src/rv_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_macros.svh"

module rv_decoder (
	input  logic [`RV_XLEN-1:0]  i_insn,
	output rv_core_pkg::decoded_t o_dec
);
	import rv_core_pkg::*;

	opcode_e             opcode;
	logic [2:0]          funct3;
	logic [6:0]          funct7;
	logic [`RV_XLEN-1:0] imm_i;
	logic [`RV_XLEN-1:0] imm_s;
	logic [`RV_XLEN-1:0] imm_b;
	logic [`RV_XLEN-1:0] imm_j;
	logic [`RV_XLEN-1:0] imm_u;

	assign opcode = opcode_e'(i_insn[6:0]);
	assign funct3 = i_insn[14:12];
	assign funct7 = i_insn[31:25];

	assign imm_i = {{20{i_insn[31]}}, i_insn[31:20]};
	assign imm_s = {{20{i_insn[31]}}, i_insn[31:25], i_insn[11:7]};
	assign imm_b = {{19{i_insn[31]}}, i_insn[31], i_insn[7], i_insn[30:25], i_insn[11:8], 1'b0};
	assign imm_j = {{11{i_insn[31]}}, i_insn[31], i_insn[19:12], i_insn[20], i_insn[30:21], 1'b0};
	assign imm_u = {i_insn[31:12], 12'b0};

	always_comb begin
		o_dec = '0;
		o_dec.opcode = opcode;
		o_dec.rd = i_insn[11:7];
		o_dec.rs1 = i_insn[19:15];
		o_dec.rs2 = i_insn[24:20];
		o_dec.funct3 = funct3;
		o_dec.alu_op = ADD; // Address and link arithmetic.
		o_dec.size = mem_size_e'(funct3[1:0]);
		o_dec.is_unsigned = funct3[2];

		case (opcode)
			LUI, AUIPC: o_dec.imm = imm_u;
			JAL: o_dec.imm = imm_j;
			JALR: begin
				o_dec.imm = imm_i;
				o_dec.illegal = (funct3 != 3'b000);
			end
			BRANCH: begin
				o_dec.imm = imm_b;
				o_dec.illegal = (funct3[2:1] == 2'b01);
			end
			LOAD: begin
				o_dec.imm = imm_i;
				o_dec.illegal = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
			end
			STORE: begin
				o_dec.imm = imm_s;
				o_dec.illegal = funct3[2] || (funct3 == 3'b011);
			end
			OP_IMM: begin
				o_dec.imm = imm_i;
				o_dec.alu_op = alu_op_e'({1'b0, funct3});
				if (funct3 == 3'b001) begin
					o_dec.illegal = (funct7 != 7'b0000000);
				end else if (funct3 == 3'b101) begin
					// Shift type sits in the upper immediate bits.
					o_dec.alu_op = alu_op_e'({funct7[5], funct3});
					o_dec.illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
				end
			end
			OP: begin
				o_dec.alu_op = alu_op_e'({funct7[5], funct3});
				o_dec.illegal = !((funct7 == 7'b0000000) ||
					((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101))));
			end
			MISC_MEM: o_dec.illegal = (funct3 != 3'b000); // Plain FENCE only.
			SYSTEM: o_dec.illegal = (i_insn[31:7] != '0); // ECALL only.
			default: o_dec.illegal = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

/* src/rv_alu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_macros.svh"

module rv_alu (
	input  rv_core_pkg::alu_op_e i_op,
	input  logic [`RV_XLEN-1:0]  i_a,
	input  logic [`RV_XLEN-1:0]  i_b,
	input  logic [2:0]           i_funct3,
	output logic [`RV_XLEN-1:0]  o_result,
	output logic                 o_branch_taken
);
	import rv_core_pkg::*;

	logic [4:0] shamt;
	logic       eq;
	logic       lt_signed;
	logic       lt_unsigned;

	assign shamt = i_b[4:0];
	assign eq = (i_a == i_b);
	assign lt_signed = ($signed(i_a) < $signed(i_b));
	assign lt_unsigned = (i_a < i_b);

	always_comb begin
		case (i_op)
			ADD:  o_result = i_a + i_b;
			SUB:  o_result = i_a - i_b;
			SLL:  o_result = i_a << shamt;
			SLT:  o_result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
			SLTU: o_result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
			XOR:  o_result = i_a ^ i_b;
			SRL:  o_result = i_a >> shamt;
			SRA:  o_result = $signed(i_a) >>> shamt;
			OR:   o_result = i_a | i_b;
			AND:  o_result = i_a & i_b;
			default: o_result = '0;
		endcase
	end

	// Branch condition from funct3.
	always_comb begin
		case (i_funct3)
			3'b000: o_branch_taken = eq;
			3'b001: o_branch_taken = !eq;
			3'b100: o_branch_taken = lt_signed;
			3'b101: o_branch_taken = !lt_signed;
			3'b110: o_branch_taken = lt_unsigned;
			3'b111: o_branch_taken = !lt_unsigned;
			default: o_branch_taken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* src/rv_reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_macros.svh"

module rv_reg_file (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             i_we,
	input  logic [$clog2(`RV_NUM_REGS)-1:0] i_rd,
	input  logic [`RV_XLEN-1:0]              i_rd_data,
	input  logic [$clog2(`RV_NUM_REGS)-1:0] i_rs1,
	input  logic [$clog2(`RV_NUM_REGS)-1:0] i_rs2,
	output logic [`RV_XLEN-1:0]              o_rs1_data,
	output logic [`RV_XLEN-1:0]              o_rs2_data
);
	logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `RV_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_we && (i_rd != '0)) begin
			regs[i_rd] <= i_rd_data;
		end
	end

	assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1]; // x0 reads as zero.
	assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

`default_nettype wire

/* src/rv_load_store_unit.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_macros.svh"

module rv_load_store_unit (
	input  logic                   i_is_store,
	input  logic                   i_is_load,
	input  rv_core_pkg::mem_size_e i_size,
	input  logic                   i_unsigned,
	input  logic [`RV_XLEN-1:0]    i_addr,
	input  logic [`RV_XLEN-1:0]    i_store_data,
	input  logic [`RV_XLEN-1:0]    i_load_word,
	output rv_core_pkg::dmem_req_t o_req,
	output logic [`RV_XLEN-1:0]    o_load_data,
	output logic                   o_misaligned
);
	import rv_core_pkg::*;

	logic [1:0]          offset;
	logic [3:0]          be_base;
	logic [`RV_XLEN-1:0] load_shifted;

	assign offset = i_addr[1:0];

	always_comb begin
		case (i_size)
			BYTE: be_base = 4'b0001;
			HALF: be_base = 4'b0011;
			default: be_base = 4'b1111;
		endcase
	end

	assign o_misaligned = (i_is_load || i_is_store) &&
		(((i_size == HALF) && offset[0]) || ((i_size == WORD) && (offset != 2'b00)));

	// Store lane placement.
	assign o_req.addr = i_addr[`RV_XLEN-1:2];
	assign o_req.be = i_is_store ? (be_base << offset) : 4'b0000;
	assign o_req.data = i_store_data << {offset, 3'b000};

	assign load_shifted = i_load_word >> {offset, 3'b000}; // Addressed byte to bit 0.

	always_comb begin
		case (i_size)
			BYTE: begin
				o_load_data = {{24{!i_unsigned && load_shifted[7]}}, load_shifted[7:0]};
			end
			HALF: begin
				o_load_data = {{16{!i_unsigned && load_shifted[15]}}, load_shifted[15:0]};
			end
			default: o_load_data = i_load_word;
		endcase
	end

endmodule

`default_nettype wire

/* src/rv_core.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_macros.svh"

module rv_core (
	input  logic                   clk,
	input  logic                   rst,
	output logic [`RV_XLEN-1:0]    o_pc,
	input  logic [`RV_XLEN-1:0]    i_insn,
	output rv_core_pkg::dmem_req_t o_dmem,
	input  logic [`RV_XLEN-1:0]    i_load_word,
	output logic                   o_halt,
	output rv_core_pkg::retire_t   o_retire
);
	import rv_core_pkg::*;

	decoded_t            dec;
	dmem_req_t           lsu_req;
	logic [`RV_XLEN-1:0] pc;
	logic [`RV_XLEN-1:0] pc_next;
	logic [`RV_XLEN-1:0] pc_plus4;
	logic [`RV_XLEN-1:0] pc_imm;
	logic [`RV_XLEN-1:0] rs1_data;
	logic [`RV_XLEN-1:0] rs2_data;
	logic [`RV_XLEN-1:0] alu_b;
	logic [`RV_XLEN-1:0] alu_result;
	logic [`RV_XLEN-1:0] load_data;
	logic [`RV_XLEN-1:0] wb_data;
	logic                branch_taken;
	logic                misaligned;
	logic                run;
	logic                halted;
	logic                valid;
	logic                fault;
	logic                stop;
	logic                writes_rd;
	logic                rd_we;

	rv_decoder u_decoder (.i_insn(i_insn), .o_dec(dec));

	rv_reg_file u_reg_file (
		.clk(clk), .rst(rst), .i_we(rd_we), .i_rd(dec.rd), .i_rd_data(wb_data),
		.i_rs1(dec.rs1), .i_rs2(dec.rs2), .o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
	);

	assign alu_b = (dec.opcode inside {OP_IMM, LOAD, STORE, JALR}) ? dec.imm : rs2_data;

	rv_alu u_alu (
		.i_op(dec.alu_op), .i_a(rs1_data), .i_b(alu_b), .i_funct3(dec.funct3),
		.o_result(alu_result), .o_branch_taken(branch_taken)
	);

	rv_load_store_unit u_lsu (
		.i_is_store(dec.opcode == STORE), .i_is_load(dec.opcode == LOAD), .i_size(dec.size),
		.i_unsigned(dec.is_unsigned), .i_addr(alu_result), .i_store_data(rs2_data),
		.i_load_word(i_load_word), .o_req(lsu_req), .o_load_data(load_data),
		.o_misaligned(misaligned)
	);

	assign valid = run && !halted; // Idle for one cycle after reset.
	assign fault = dec.illegal || misaligned;
	assign stop = fault || (dec.opcode == SYSTEM); // SYSTEM that is legal is ECALL.
	assign writes_rd = dec.opcode inside {LUI, AUIPC, JAL, JALR, OP, OP_IMM, LOAD};
	assign rd_we = valid && !fault && writes_rd && (dec.rd != '0);

	assign pc_plus4 = pc + 32'd4;
	assign pc_imm = pc + dec.imm; // Branch, JAL and AUIPC share this adder.

	always_comb begin
		case (dec.opcode)
			LOAD: wb_data = load_data;
			JAL, JALR: wb_data = pc_plus4;
			LUI: wb_data = dec.imm;
			AUIPC: wb_data = pc_imm;
			default: wb_data = alu_result;
		endcase
	end

	always_comb begin
		pc_next = pc_plus4;
		if (dec.opcode == JAL || (dec.opcode == BRANCH && branch_taken)) pc_next = pc_imm;
		else if (dec.opcode == JALR) pc_next = {alu_result[`RV_XLEN-1:1], 1'b0};
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= `RV_RESET_PC;
			run <= 1'b0;
			halted <= 1'b0;
		end else begin
			run <= 1'b1;
			if (valid && stop) halted <= 1'b1;
			if (valid && !stop) pc <= pc_next;
		end
	end

	always_comb begin
		o_dmem = lsu_req;
		o_dmem.be = (valid && !fault) ? lsu_req.be : 4'b0000;
	end

	assign o_pc = pc;
	assign o_halt = halted || (valid && stop);

	assign o_retire.valid = valid;
	assign o_retire.pc = pc;
	assign o_retire.insn = i_insn;
	assign o_retire.rd_we = rd_we;
	assign o_retire.rd_idx = dec.rd;
	assign o_retire.rd_data = wb_data;
	assign o_retire.store = o_dmem;

endmodule

`default_nettype wire

/* src/rv_memory.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_macros.svh"

module rv_memory (
	input  logic                   clk,
	input  logic [`RV_XLEN-1:0]    i_pc,
	output logic [`RV_XLEN-1:0]    o_insn,
	input  rv_core_pkg::dmem_req_t i_req,
	output logic [`RV_XLEN-1:0]    o_load_word
);
	import rv_core_pkg::*;

	localparam int IDX_W = $clog2(`RV_MEM_WORDS);

	logic [`RV_XLEN-1:0] mem [`RV_MEM_WORDS];
	logic [IDX_W-1:0]    insn_idx;
	logic [IDX_W-1:0]    data_idx;

	initial $readmemh("verification/program.hex", mem);

	assign insn_idx = i_pc[IDX_W+1:2]; // Byte PC to word index.
	assign data_idx = i_req.addr[IDX_W-1:0];

	// Both ports read without a clock.
	assign o_insn = mem[insn_idx];
	assign o_load_word = mem[data_idx];

	always_ff @(posedge clk) begin
		for (int b = 0; b < 4; b++) begin
			if (i_req.be[b]) begin
				mem[data_idx][8*b +: 8] <= i_req.data[8*b +: 8];
			end
		end
	end

endmodule

`default_nettype wire

/* src/rv_system.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_macros.svh"

module rv_system (
	input  logic                 clk,
	input  logic                 rst,
	output logic                 o_halt,
	output rv_core_pkg::retire_t o_retire
);
	import rv_core_pkg::*;

	logic [`RV_XLEN-1:0] pc;
	logic [`RV_XLEN-1:0] insn;
	logic [`RV_XLEN-1:0] load_word;
	dmem_req_t           dmem;

	rv_core u_core (
		.clk(clk), .rst(rst), .o_pc(pc), .i_insn(insn), .o_dmem(dmem),
		.i_load_word(load_word), .o_halt(o_halt), .o_retire(o_retire)
	);

	rv_memory u_memory (.clk(clk), .i_pc(pc), .o_insn(insn), .i_req(dmem), .o_load_word(load_word));

endmodule

`default_nettype wire

/* verification/rv_system_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_macros.svh"

module rv_system_assertions (
	input wire logic                 clk,
	input wire logic                 rst,
	input wire logic                 o_halt,
	input wire rv_core_pkg::retire_t o_retire
);
	import rv_core_pkg::*;

	localparam logic [`RV_XLEN-1:0] ECALL_INSN = 32'h0000_0073;

	int                  errors = 0; // Read by the testbench.
	opcode_e             opc;
	logic [`RV_XLEN-1:0] jal_imm;
	logic [1:0]          st_size;
	logic [3:0]          be;

	assign opc = opcode_e'(o_retire.insn[6:0]);
	assign jal_imm = {{11{o_retire.insn[31]}}, o_retire.insn[31], o_retire.insn[19:12],
		o_retire.insn[20], o_retire.insn[30:21], 1'b0};
	assign st_size = o_retire.insn[13:12];
	assign be = o_retire.store.be;

	a_reset_quiet: assert property (@(posedge clk) $past(rst) |->
		!o_retire.valid && !o_retire.rd_we && (be == 4'b0000) && !o_halt)
		else begin $error("Trace active during or right after reset at %0t", $time); errors++; end

	a_first_pc: assert property (@(posedge clk) disable iff (rst)
		$rose(o_retire.valid) |-> (o_retire.pc == `RV_RESET_PC))
		else begin $error("First retire not at reset PC at %0t", $time); errors++; end

	a_seq_pc: assert property (@(posedge clk) disable iff (rst)
		o_retire.valid && !(opc inside {BRANCH, JAL, JALR}) |=>
		!o_retire.valid || (o_retire.pc == $past(o_retire.pc) + 32'd4))
		else begin $error("Sequential PC did not advance by 4 at %0t", $time); errors++; end

	a_jal_link: assert property (@(posedge clk) disable iff (rst)
		o_retire.valid && (opc == JAL) |-> (o_retire.rd_data == o_retire.pc + 32'd4))
		else begin $error("JAL link value wrong at %0t", $time); errors++; end

	a_jal_target: assert property (@(posedge clk) disable iff (rst)
		o_retire.valid && (opc == JAL) |=>
		!o_retire.valid || (o_retire.pc == $past(o_retire.pc) + $past(jal_imm)))
		else begin $error("JAL target wrong at %0t", $time); errors++; end

	a_x0_no_write: assert property (@(posedge clk) disable iff (rst)
		(o_retire.rd_idx == '0) |-> !o_retire.rd_we)
		else begin $error("Write enable set for x0 at %0t", $time); errors++; end

	// Byte enable shape follows the store size.
	a_store_be: assert property (@(posedge clk) disable iff (rst)
		(be != 4'b0000) |-> ((st_size == 2'd0) && (be inside {4'h1, 4'h2, 4'h4, 4'h8})) ||
		((st_size == 2'd1) && (be inside {4'h3, 4'hc})) || ((st_size == 2'd2) && (be == 4'hf)))
		else begin $error("Store byte enable malformed at %0t", $time); errors++; end

	a_halt_cause: assert property (@(posedge clk) disable iff (rst)
		o_halt && o_retire.valid |-> (o_retire.insn == ECALL_INSN))
		else begin $error("Halt raised by a non-ECALL at %0t", $time); errors++; end

	a_halt_hold: assert property (@(posedge clk) disable iff (rst)
		o_halt |=> o_halt && !o_retire.valid)
		else begin $error("Halt not held or retire after halt at %0t", $time); errors++; end

endmodule

`default_nettype wire

/* verification/rv_system_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_macros.svh"

module rv_system_tb;
	import rv_core_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int PROG_WORDS = 63;
	localparam int RESET_CYCLES = 5;
	localparam int TIMEOUT_NS = (PROG_WORDS + RESET_CYCLES + 50) * CLK_PERIOD;
	localparam int NUM_EXP = 34;
	localparam logic [`RV_XLEN-1:0] ECALL_INSN = 32'h0000_0073;

	// Each entry is {rd, value} in program order.
	localparam logic [36:0] EXPECTED [NUM_EXP] = '{
		{5'd1, 32'h1234_5000}, {5'd2, 32'h0000_1004},
		{5'd3, 32'hffff_fff9}, {5'd4, 32'h0000_0005},
		{5'd5, 32'h0000_0001}, {5'd6, 32'h0000_0000},
		{5'd7, 32'h0000_00f5}, {5'd8, 32'h0000_0105},
		{5'd9, 32'h0000_00f9}, {5'd10, 32'h0000_0050},
		{5'd11, 32'h0000_000f}, {5'd12, 32'hffff_fffc},
		{5'd13, 32'hffff_fffe}, {5'd14, 32'h0000_000c},
		{5'd15, 32'h0000_00a0}, {5'd16, 32'h0000_0001},
		{5'd17, 32'h0000_0000}, {5'd18, 32'hffff_fffc},
		{5'd19, 32'h07ff_ffff}, {5'd20, 32'hffff_ffff},
		{5'd21, 32'hffff_fffd}, {5'd22, 32'h0000_0001},
		{5'd23, 32'h0000_0400}, {5'd24, 32'hffff_fff5},
		{5'd25, 32'h0000_00f9}, {5'd26, 32'h0000_0050},
		{5'd27, 32'hffff_fff9}, {5'd28, 32'h0000_fff9},
		{5'd29, 32'h0000_1004}, {5'd30, 32'h1234_5000},
		{5'd31, 32'h50f9_05f5}, {5'd1, 32'h0000_00e8},
		{5'd5, 32'h0000_00f8}, {5'd6, 32'h0000_00f4}
	};

	logic                clk;
	logic                rst;
	logic                o_halt;
	retire_t             o_retire;
	logic [`RV_XLEN-1:0] model [`RV_NUM_REGS];
	int                  exp_idx;
	int                  idle_cycles;
	logic                ecall_seen;

	rv_system i_dut (.clk(clk), .rst(rst), .o_halt(o_halt), .o_retire(o_retire));

	bind rv_system rv_system_assertions u_assertions (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1);
	endtask

	// Store goes to rs1 + imm with the size's lanes holding rs2.
	function automatic logic store_matches(input retire_t r);
		logic [`RV_XLEN-1:0] addr;
		logic [`RV_XLEN-1:0] lane;
		logic [3:0]          be_exp;
		logic                ok;
		addr = model[r.insn[19:15]] + {{20{r.insn[31]}}, r.insn[31:25], r.insn[11:7]};
		case (r.insn[13:12])
			2'd0: be_exp = 4'b0001;
			2'd1: be_exp = 4'b0011;
			default: be_exp = 4'b1111;
		endcase
		be_exp = be_exp << addr[1:0];
		lane = model[r.insn[24:20]] << (8 * addr[1:0]);
		ok = (r.insn[6:0] == STORE) && (r.store.be == be_exp) &&
			(r.store.addr == addr[`RV_XLEN-1:2]);
		for (int b = 0; b < 4; b++) begin
			if (be_exp[b] && (r.store.data[8*b +: 8] != lane[8*b +: 8])) ok = 1'b0;
		end
		return ok;
	endfunction

	always @(negedge clk) begin
		if (i_dut.u_assertions.errors != 0) begin
			abort_run("An assertion on the retire trace failed");
		end else if (!rst && o_retire.valid) begin
			if (((o_retire.insn[6:0] == STORE) || (o_retire.store.be != 4'b0000)) &&
				!store_matches(o_retire)) begin
				abort_run($sformatf("** Error at %0t: store word %h be %b data %h wrong for x%0d",
					$time, o_retire.store.addr, o_retire.store.be, o_retire.store.data,
					o_retire.insn[24:20]));
			end else if (o_retire.rd_we && ((exp_idx >= NUM_EXP) ||
				({o_retire.rd_idx, o_retire.rd_data} != EXPECTED[exp_idx]))) begin
				abort_run($sformatf("** Error at %0t: write x%0d = %h, expected entry %0d",
					$time, o_retire.rd_idx, o_retire.rd_data, exp_idx));
			end else if ((o_retire.insn == ECALL_INSN) && (exp_idx != NUM_EXP)) begin
				abort_run("ECALL retired before all expected register writes were seen");
			end else begin
				if (o_retire.rd_we) begin
					model[o_retire.rd_idx] = o_retire.rd_data;
					exp_idx++;
				end
				if (o_retire.insn == ECALL_INSN) ecall_seen = 1'b1;
			end
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Program never halted within the time limit");
		$display("Regression failed");
		$fatal(1);
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		exp_idx = 0;
		ecall_seen = 1'b0;
		for (int i = 0; i < `RV_NUM_REGS; i++) model[i] = '0;
		void'($urandom(9));
		idle_cycles = 2 + ($urandom % 8);
		repeat (RESET_CYCLES) @(posedge clk);
		#2 rst = 1'b0;
		do @(negedge clk); while (o_halt !== 1'b1);
		repeat (idle_cycles) @(negedge clk);
		if (ecall_seen && (exp_idx == NUM_EXP) && (i_dut.u_assertions.errors == 0)) begin
			$display("Regression passed");
			$finish;
		end else begin
			abort_run("Core halted without a clean ECALL after all expected writes");
		end
	end

endmodule

`default_nettype wire

/* verification/program.hex */
// Program image: 32-bit instruction words in address order, four per line.
// Words 00000000 are traps placed where a taken branch or jump must skip.
123450B7 00001117 FF900193 00500213 // 0x000 lui, auipc, addi x3, addi x4
0001A293 00323313 0F024393 10026413 // 0x010 slti, sltiu, xori, ori
0FF1F493 00421513 01C1D593 4011D613 // 0x020 andi, slli, srli, srai
004186B3 40320733 004217B3 0041A833 // 0x030 add, sub, sll, slt
0041B8B3 0041C933 0041D9B3 4041DA33 // 0x040 sltu, xor, srl, sra
0041EAB3 0041FB33 00120013 40000B93 // 0x050 or, and, write to x0, base 0x400
007B8023 008B80A3 009B8123 00AB81A3 // 0x060 sb at offsets 0 to 3
003B9223 002B9323 001BA423 000B8C03 // 0x070 sh, sh, sw, lb
002BCC83 003B8D03 004B9D83 004BDE03 // 0x080 lbu, lb, lh, lhu
006BDE83 008BAF03 000BAF83 00320463 // 0x090 lhu, lw, lw, beq not taken
00420463 00000000 00421463 00321463 // 0x0a0 beq taken, trap, bne, bne
00000000 00324463 0041C463 00000000 // 0x0b0 trap, blt, blt, trap
0041D463 00325463 00000000 00326463 // 0x0c0 bge, bge, trap, bltu
00000000 0041E463 00327463 0041F463 // 0x0d0 trap, bltu, bgeu, bgeu
00000000 008000EF 00000000 0F800293 // 0x0e0 trap, jal, trap, addi x5
00128367 00000000 00000073          // 0x0f0 jalr, trap, ecall

/* flist.f */
+incdir+include
src/rv_core_pkg.sv
src/rv_decoder.sv
src/rv_alu.sv
src/rv_reg_file.sv
src/rv_load_store_unit.sv
src/rv_core.sv
src/rv_memory.sv
src/rv_system.sv
verification/rv_system_assertions.sv
verification/rv_system_tb.sv

/* Bender.yml */
package:
  name: rv_system

sources:
  - include_dirs:
      - include
    files:
      - src/rv_core_pkg.sv
      - src/rv_decoder.sv
      - src/rv_alu.sv
      - src/rv_reg_file.sv
      - src/rv_load_store_unit.sv
      - src/rv_core.sv
      - src/rv_memory.sv
      - src/rv_system.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/rv_system_assertions.sv
      - verification/rv_system_tb.sv
